// ==== hw/qstate_pkg.sv ====
////////////////////////////////////////
// Sizes, vector types and allocator states shared by the
// queue state keeper. Imported inside each module body
////////////////////////////////////////

package qstate_pkg;

    ////////////////////////////////////////
    // Buffer geometry
    localparam int NUM_QUEUES     = 8;
    localparam int NUM_PAGES      = 32;
    localparam int WORDS_PER_PAGE = 16;
    localparam int BYTES_PER_WORD = 64;
    localparam int MTU_BYTES      = 960;

    ////////////////////////////////////////
    // Derived widths
    localparam int QUEUE_W    = $clog2(NUM_QUEUES);
    localparam int PAGE_W     = $clog2(NUM_PAGES);
    localparam int WORD_W     = $clog2(WORDS_PER_PAGE);
    localparam int BLEN_W     = $clog2(MTU_BYTES + 1);
    localparam int OCC_W      = $clog2(NUM_PAGES * WORDS_PER_PAGE * BYTES_PER_WORD + 1);
    // Byte count to word count shift
    localparam int BYTE_SHIFT = $clog2(BYTES_PER_WORD);

    typedef logic [QUEUE_W-1:0] queue_id_t;
    typedef logic [PAGE_W-1:0]  page_id_t;
    typedef logic [WORD_W-1:0]  word_idx_t;
    typedef logic [BLEN_W-1:0]  blen_t;
    typedef logic [OCC_W-1:0]   occ_t;
    // Must hold NUM_PAGES itself
    typedef logic [PAGE_W:0]    page_cnt_t;

    // Free list fill after reset, then normal operation
    typedef enum logic {
        alloc_init,
        alloc_run
    } alloc_state_t;

endpackage

// ==== hw/qstate_ifc.sv ====
////////////////////////////////////////
// Internal buses between the trackers and the page allocator
////////////////////////////////////////

`timescale 1ns/1ns

// Page request from the tail side
interface page_alloc_if;
    import qstate_pkg::*;

    logic     req;
    page_id_t prev_page;
    page_id_t grant_page;
    logic     avail;

    modport source (
        output req, prev_page,
        input  grant_page, avail
    );

    modport target (
        input  req, prev_page,
        output grant_page, avail
    );
endinterface

// Page return from the head side
interface page_free_if;
    import qstate_pkg::*;

    logic     free;
    page_id_t free_page;
    page_id_t next_page;
    logic     ready;

    modport source (
        output free, free_page,
        input  next_page, ready
    );

    modport target (
        input  free, free_page,
        output next_page, ready
    );
endinterface

// Byte count updates toward the occupancy tracker
interface occ_update_if;
    import qstate_pkg::*;

    logic      enq_valid;
    queue_id_t enq_queue;
    blen_t     enq_blen;
    logic      deq_valid;
    queue_id_t deq_queue;
    blen_t     deq_blen;

    modport enqueue (output enq_valid, enq_queue, enq_blen);
    modport dequeue (output deq_valid, deq_queue, deq_blen);
    modport receiver (input enq_valid, enq_queue, enq_blen, deq_valid, deq_queue, deq_blen);
endinterface

// ==== hw/page_allocator.sv ====
////////////////////////////////////////
// Free page FIFO and page link table. Grants pages to the tail
// tracker and takes back pages released by the head tracker
////////////////////////////////////////

`timescale 1ns/1ns

module page_allocator (
    input  logic                  core_clk_ifc,
    input  logic                  rst_n,
    page_alloc_if.target          alloc,
    page_free_if.target           page_ret,
    output qstate_pkg::page_cnt_t free_page_count
);
    import qstate_pkg::*;

    alloc_state_t state;
    page_id_t     init_page;
    page_id_t     rd_ptr;
    page_id_t     wr_ptr;
    page_cnt_t    page_count;

    // Free list storage and next-page links
    page_id_t free_fifo [NUM_PAGES];
    page_id_t link_mem  [NUM_PAGES];

    logic     push_valid;
    page_id_t push_page;

    ////////////////////////////////////////
    // Push source selection

    // During init the FIFO is filled with the pages not owned by a queue
    assign push_valid = (state == alloc_init) || page_ret.free;
    assign push_page  = (state == alloc_init) ? init_page : page_ret.free_page;

    assign alloc.avail      = (state == alloc_run) && (page_count != '0);
    assign alloc.grant_page = free_fifo[rd_ptr];

    assign page_ret.next_page = link_mem[page_ret.free_page];
    assign page_ret.ready     = (state == alloc_run);

    assign free_page_count = page_count;

    ////////////////////////////////////////
    // Control state

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            state      <= alloc_init;
            init_page  <= page_id_t'(NUM_QUEUES);
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            page_count <= '0;
        end else begin
            if (state == alloc_init) begin
                init_page <= init_page + 1'b1;
                if (init_page == page_id_t'(NUM_PAGES - 1)) begin
                    state <= alloc_run;
                end
            end
            if (alloc.req) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // Pop and push can meet in one cycle
            page_count <= page_count + page_cnt_t'(push_valid) - page_cnt_t'(alloc.req);
        end
    end

    ////////////////////////////////////////
    // Storage

    always_ff @(posedge core_clk_ifc) begin
        if (push_valid) begin
            free_fifo[wr_ptr] <= push_page;
        end
        // The old tail page now continues on the granted page
        if (alloc.req) begin
            link_mem[alloc.prev_page] <= alloc.grant_page;
        end
    end

endmodule

// ==== hw/tail_tracker.sv ====
////////////////////////////////////////
// Per-queue tail position. Places each enqueued packet and
// requests a new page when the packet reaches the page end
////////////////////////////////////////

`timescale 1ns/1ns

module tail_tracker (
    input  logic                  core_clk_ifc,
    input  logic                  rst_n,
    input  logic                  enq_valid,
    input  qstate_pkg::queue_id_t enq_queue,
    input  qstate_pkg::blen_t     enq_blen,
    output logic                  enq_ready,
    output logic                  enq_resp_valid,
    output qstate_pkg::page_id_t  enq_resp_page,
    output qstate_pkg::word_idx_t enq_resp_word,
    page_alloc_if.source          alloc,
    occ_update_if.enqueue         occ
);
    import qstate_pkg::*;

    word_idx_t tail_word [NUM_QUEUES];
    page_id_t  tail_page [NUM_QUEUES];

    logic              enq_accept;
    logic [BLEN_W:0]   blen_round;
    logic [WORD_W:0]   pkt_words;
    logic [WORD_W:0]   tail_sum;
    logic              need_page;

    // Busy for one cycle after each accepted packet
    assign enq_ready  = !enq_resp_valid && alloc.avail;
    assign enq_accept = enq_valid && enq_ready;

    // Words taken by the packet, rounded up
    assign blen_round = {1'b0, enq_blen} + (BLEN_W + 1)'(BYTES_PER_WORD - 1);
    assign pkt_words  = (WORD_W + 1)'(blen_round >> BYTE_SHIFT);
    assign tail_sum   = {1'b0, tail_word[enq_queue]} + pkt_words;
    assign need_page  = tail_sum >= (WORD_W + 1)'(WORDS_PER_PAGE);

    assign alloc.req       = enq_accept && need_page;
    assign alloc.prev_page = tail_page[enq_queue];

    ////////////////////////////////////////
    // Tail pointers

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                tail_word[q] <= '0;
                // Each queue owns page q from reset
                tail_page[q] <= page_id_t'(q);
            end
            enq_resp_valid <= 1'b0;
            occ.enq_valid  <= 1'b0;
        end else begin
            enq_resp_valid <= enq_accept;
            occ.enq_valid  <= enq_accept;
            if (enq_accept) begin
                if (need_page) begin
                    tail_word[enq_queue] <= word_idx_t'(tail_sum - (WORD_W + 1)'(WORDS_PER_PAGE));
                    tail_page[enq_queue] <= alloc.grant_page;
                end else begin
                    tail_word[enq_queue] <= word_idx_t'(tail_sum);
                end
            end
        end
    end

    ////////////////////////////////////////
    // Response and occupancy payload

    always_ff @(posedge core_clk_ifc) begin
        if (enq_accept) begin
            enq_resp_page <= tail_page[enq_queue];
            enq_resp_word <= tail_word[enq_queue];
            occ.enq_queue <= enq_queue;
            occ.enq_blen  <= enq_blen;
        end
    end

endmodule

// ==== hw/head_tracker.sv ====
////////////////////////////////////////
// Per-queue head position. Reports the read address of each
// dequeued word and returns pages once fully read
////////////////////////////////////////

`timescale 1ns/1ns

module head_tracker (
    input  logic                             core_clk_ifc,
    input  logic                             rst_n,
    input  logic                             deq_valid,
    input  qstate_pkg::queue_id_t            deq_queue,
    input  qstate_pkg::blen_t                deq_blen,
    input  logic [qstate_pkg::NUM_QUEUES-1:0] queue_empty,
    output logic                             deq_resp_valid,
    output qstate_pkg::page_id_t             deq_resp_page,
    output qstate_pkg::word_idx_t            deq_resp_word,
    page_free_if.source                      page_ret,
    occ_update_if.dequeue                    occ
);
    import qstate_pkg::*;

    word_idx_t head_word [NUM_QUEUES];
    page_id_t  head_page [NUM_QUEUES];

    logic deq_accept;
    logic page_end;

    // Requests to an empty queue are dropped
    assign deq_accept = deq_valid && !queue_empty[deq_queue] && page_ret.ready;
    assign page_end   = head_word[deq_queue] == word_idx_t'(WORDS_PER_PAGE - 1);

    assign page_ret.free      = deq_accept && page_end;
    assign page_ret.free_page = head_page[deq_queue];

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                head_word[q] <= '0;
                head_page[q] <= page_id_t'(q);
            end
            deq_resp_valid <= 1'b0;
            occ.deq_valid  <= 1'b0;
        end else begin
            deq_resp_valid <= deq_accept;
            occ.deq_valid  <= deq_accept;
            if (deq_accept) begin
                if (page_end) begin
                    // Follow the link to the queue's next page
                    head_word[deq_queue] <= '0;
                    head_page[deq_queue] <= page_ret.next_page;
                end else begin
                    head_word[deq_queue] <= head_word[deq_queue] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (deq_accept) begin
            deq_resp_page <= head_page[deq_queue];
            deq_resp_word <= head_word[deq_queue];
            occ.deq_queue <= deq_queue;
            occ.deq_blen  <= deq_blen;
        end
    end

endmodule

// ==== hw/occupancy_tracker.sv ====
////////////////////////////////////////
// Per-queue byte occupancy and empty flags, fed by both the
// enqueue and the dequeue side
////////////////////////////////////////

`timescale 1ns/1ns

module occupancy_tracker (
    input  logic                              core_clk_ifc,
    input  logic                              rst_n,
    occ_update_if.receiver                    occ,
    output logic [qstate_pkg::NUM_QUEUES-1:0] queue_empty
);
    import qstate_pkg::*;

    occ_t occ_bytes [NUM_QUEUES];
    occ_t occ_next  [NUM_QUEUES];

    ////////////////////////////////////////
    // Next occupancy

    // Both updates may hit the same queue in one cycle
    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            occ_next[q] = occ_bytes[q];
            if (occ.enq_valid && (occ.enq_queue == queue_id_t'(q))) begin
                occ_next[q] = occ_next[q] + occ_t'(occ.enq_blen);
            end
            if (occ.deq_valid && (occ.deq_queue == queue_id_t'(q))) begin
                occ_next[q] = occ_next[q] - occ_t'(occ.deq_blen);
            end
        end
    end

    ////////////////////////////////////////
    // Registered counts and flags

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                occ_bytes[q] <= '0;
            end
            queue_empty <= '1;
        end else begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                occ_bytes[q]   <= occ_next[q];
                queue_empty[q] <= (occ_next[q] == '0);
            end
        end
    end

endmodule

// ==== hw/qstate_top.sv ====
////////////////////////////////////////
// Queue state keeper top. Enqueue and dequeue requests in,
// buffer addresses, empty flags and free page count out
////////////////////////////////////////

`timescale 1ns/1ns

module qstate_top (
    input  logic                              core_clk_ifc,
    input  logic                              rst_n,
    input  logic                              enq_valid,
    input  qstate_pkg::queue_id_t             enq_queue,
    input  qstate_pkg::blen_t                 enq_blen,
    input  logic                              deq_valid,
    input  qstate_pkg::queue_id_t             deq_queue,
    input  qstate_pkg::blen_t                 deq_blen,
    output logic                              enq_ready,
    output logic                              enq_resp_valid,
    output qstate_pkg::page_id_t              enq_resp_page,
    output qstate_pkg::word_idx_t             enq_resp_word,
    output logic                              deq_resp_valid,
    output qstate_pkg::page_id_t              deq_resp_page,
    output qstate_pkg::word_idx_t             deq_resp_word,
    output logic [qstate_pkg::NUM_QUEUES-1:0] queue_empty,
    output qstate_pkg::page_cnt_t             free_page_count
);

    page_alloc_if alloc_bus ();
    page_free_if  free_bus ();
    occ_update_if occ_bus ();

    page_allocator page_allocator_inst (
        .core_clk_ifc    (core_clk_ifc),
        .rst_n           (rst_n),
        .alloc           (alloc_bus),
        .page_ret        (free_bus),
        .free_page_count (free_page_count)
    );

    tail_tracker tail_tracker_inst (
        .core_clk_ifc   (core_clk_ifc),
        .rst_n          (rst_n),
        .enq_valid      (enq_valid),
        .enq_queue      (enq_queue),
        .enq_blen       (enq_blen),
        .enq_ready      (enq_ready),
        .enq_resp_valid (enq_resp_valid),
        .enq_resp_page  (enq_resp_page),
        .enq_resp_word  (enq_resp_word),
        .alloc          (alloc_bus),
        .occ            (occ_bus)
    );

    // Empty flags gate the dequeue side
    head_tracker head_tracker_inst (
        .core_clk_ifc   (core_clk_ifc),
        .rst_n          (rst_n),
        .deq_valid      (deq_valid),
        .deq_queue      (deq_queue),
        .deq_blen       (deq_blen),
        .queue_empty    (queue_empty),
        .deq_resp_valid (deq_resp_valid),
        .deq_resp_page  (deq_resp_page),
        .deq_resp_word  (deq_resp_word),
        .page_ret       (free_bus),
        .occ            (occ_bus)
    );

    occupancy_tracker occupancy_tracker_inst (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .occ          (occ_bus),
        .queue_empty  (queue_empty)
    );

endmodule

// ==== testbench/qstate_checker.sv ====
////////////////////////////////////////
// Handshake and free count assertions bound into the top level
////////////////////////////////////////

`timescale 1ns/1ns

module qstate_checker (
    input logic                              core_clk_ifc,
    input logic                              rst_n,
    input logic                              enq_valid,
    input logic                              enq_ready,
    input logic                              enq_resp_valid,
    input logic                              deq_valid,
    input qstate_pkg::queue_id_t             deq_queue,
    input logic                              deq_resp_valid,
    input logic [qstate_pkg::NUM_QUEUES-1:0] queue_empty,
    input qstate_pkg::page_cnt_t             free_page_count
);
    import qstate_pkg::*;

    ////////////////////////////////////////
    // Enqueue side

    // Accepted packet answers on the next cycle, and only then
    enq_resp_after_accept: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        enq_valid && enq_ready |=> enq_resp_valid)
        else $error("enqueue accepted without a response pulse");

    enq_resp_only_after_accept: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        !(enq_valid && enq_ready) |=> !enq_resp_valid)
        else $error("enqueue response without an accepted request");

    // Pages leave the free list only for an accepted packet
    free_count_drop_needs_enq: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        !(enq_valid && enq_ready) |=> free_page_count >= $past(free_page_count))
        else $error("free page count dropped without an accepted enqueue");

    ////////////////////////////////////////
    // Dequeue side and free list

    deq_resp_when_not_empty: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        deq_valid && !queue_empty[deq_queue] |=> deq_resp_valid)
        else $error("dequeue on a non-empty queue gave no response");

    deq_no_resp_when_empty: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        !(deq_valid && !queue_empty[deq_queue]) |=> !deq_resp_valid)
        else $error("dequeue response without a valid request");

    free_count_in_range: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        free_page_count <= page_cnt_t'(NUM_PAGES - NUM_QUEUES))
        else $error("free page count above the number of spare pages");

    ready_needs_free_page: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        enq_ready |-> free_page_count != '0)
        else $error("enq_ready high with an empty free list");

endmodule

bind qstate_top qstate_checker qstate_checker_inst (
    .core_clk_ifc    (core_clk_ifc),
    .rst_n           (rst_n),
    .enq_valid       (enq_valid),
    .enq_ready       (enq_ready),
    .enq_resp_valid  (enq_resp_valid),
    .deq_valid       (deq_valid),
    .deq_queue       (deq_queue),
    .deq_resp_valid  (deq_resp_valid),
    .queue_empty     (queue_empty),
    .free_page_count (free_page_count)
);

// ==== testbench/qstate_tb.sv ====
////////////////////////////////////////
// Testbench for the queue state keeper. Directed and random traffic
// checked against a model of queue pages and the free list
////////////////////////////////////////

`timescale 1ns/1ns

module qstate_tb;
    import qstate_pkg::*;

    logic                  core_clk_ifc = 1'b0;
    logic                  rst_n;
    logic                  enq_valid;
    queue_id_t             enq_queue;
    blen_t                 enq_blen;
    logic                  deq_valid;
    queue_id_t             deq_queue;
    blen_t                 deq_blen;
    logic                  enq_ready;
    logic                  enq_resp_valid;
    page_id_t              enq_resp_page;
    word_idx_t             enq_resp_word;
    logic                  deq_resp_valid;
    page_id_t              deq_resp_page;
    word_idx_t             deq_resp_word;
    logic [NUM_QUEUES-1:0] queue_empty;
    page_cnt_t             free_page_count;

    ////////////////////////////////////////
    // Reference model with the head page at the front of each page list
    int   pages [NUM_QUEUES][$];
    int   word_bytes [NUM_QUEUES][$];
    int   tail_w [NUM_QUEUES];
    int   head_w [NUM_QUEUES];
    int   occ [NUM_QUEUES];
    int   free_q [$];

    int   checks;
    int   errors;
    int   errors_seen;
    logic timed_out;

    qstate_top qstate_top_inst (.*);

    always #2 core_clk_ifc = ~core_clk_ifc;

    function automatic void model_enq(input int q, input int blen, output int p, output int w);
        int n;
        // Words per packet, rounded up
        n = (blen + BYTES_PER_WORD - 1) / BYTES_PER_WORD;
        p = pages[q][$];
        w = tail_w[q];
        for (int i = 0; i < n; i++) begin
            word_bytes[q].push_back((i < n - 1) ? BYTES_PER_WORD : blen - (n - 1) * BYTES_PER_WORD);
        end
        occ[q] += blen;
        tail_w[q] += n;
        if (tail_w[q] >= WORDS_PER_PAGE) begin
            pages[q].push_back(free_q.pop_front());
            tail_w[q] -= WORDS_PER_PAGE;
        end
    endfunction

    function automatic void model_deq(input int q, output int p, output int w, output int b);
        p = pages[q][0];
        w = head_w[q];
        b = word_bytes[q].pop_front();
        occ[q] -= b;
        if (head_w[q] == WORDS_PER_PAGE - 1) begin
            free_q.push_back(pages[q].pop_front());
            head_w[q] = 0;
        end else begin
            head_w[q]++;
        end
    endfunction

    task automatic step();
        @(posedge core_clk_ifc);
        #1;
    endtask

    task automatic check(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Fail %0t: %s", $time, what);
        end
    endtask

    task automatic report(input string name);
        $display("Test %s finished, %0d errors", name, errors - errors_seen);
        errors_seen = errors;
    endtask

    // One enqueue and/or dequeue cycle, then the empty flags settle
    task automatic run_op(input logic de, input int eq, input int eb, input logic dd, input int dq);
        int   t;
        int   ep;
        int   ew;
        int   dp;
        int   dw;
        int   db;
        logic deq_ok;
        if (timed_out) return;
        t = 0;
        while (de && !enq_ready && t < 200) begin
            step();
            t++;
        end
        if (t >= 200) begin
            $display("Timeout at %0t: enq_ready stayed low for queue %0d", $time, eq);
            timed_out = 1'b1;
            return;
        end
        deq_ok = dd && (word_bytes[dq].size() > 0);
        db = BYTES_PER_WORD;
        if (deq_ok) model_deq(dq, dp, dw, db);
        if (de) model_enq(eq, eb, ep, ew);
        enq_valid = de;
        enq_queue = queue_id_t'(eq);
        enq_blen  = blen_t'(eb);
        deq_valid = dd;
        deq_queue = queue_id_t'(dq);
        deq_blen  = blen_t'(db);
        step();
        enq_valid = 1'b0;
        deq_valid = 1'b0;
        if (de) begin
            check(enq_resp_valid && enq_resp_page == ep && enq_resp_word == ew,
                $sformatf("enqueue q%0d valid %0b page %0d word %0d, expected page %0d word %0d",
                          eq, enq_resp_valid, enq_resp_page, enq_resp_word, ep, ew));
        end
        check(deq_resp_valid == deq_ok, $sformatf("dequeue q%0d response valid %0b, expected %0b",
                                                  dq, deq_resp_valid, deq_ok));
        if (deq_ok) begin
            check(deq_resp_page == dp && deq_resp_word == dw,
                $sformatf("dequeue q%0d page %0d word %0d, expected page %0d word %0d",
                          dq, deq_resp_page, deq_resp_word, dp, dw));
        end
        check(free_page_count == free_q.size(), $sformatf("free page count %0d, expected %0d",
                                                          free_page_count, free_q.size()));
        step();
        for (int q = 0; q < NUM_QUEUES; q++) begin
            check(queue_empty[q] == (occ[q] == 0),
                $sformatf("queue %0d empty flag %0b with %0d bytes", q, queue_empty[q], occ[q]));
        end
    endtask

    initial begin
        int r;
        int q;
        int guard;
        void'($urandom(32'hcd63_87d7));
        rst_n       = 1'b0;
        enq_valid   = 1'b0;
        enq_queue   = '0;
        enq_blen    = '0;
        deq_valid   = 1'b0;
        deq_queue   = '0;
        deq_blen    = '0;
        checks      = 0;
        errors      = 0;
        errors_seen = 0;
        timed_out   = 1'b0;
        for (int k = 0; k < NUM_QUEUES; k++) begin
            pages[k].push_back(k);
            tail_w[k] = 0;
            head_w[k] = 0;
            occ[k]    = 0;
        end
        for (int p = NUM_QUEUES; p < NUM_PAGES; p++) begin
            free_q.push_back(p);
        end

        for (int i = 0; i < 5; i++) begin
            step();
        end
        check(queue_empty == '1 && !enq_resp_valid && !deq_resp_valid && !enq_ready,
              "outputs not at their reset values");
        rst_n = 1'b1;
        guard = 0;
        while (!enq_ready && guard < 200) begin
            step();
            guard++;
        end
        if (guard >= 200) begin
            $display("Timeout at %0t: enq_ready never rose after reset", $time);
            timed_out = 1'b1;
        end
        check(free_page_count == page_cnt_t'(NUM_PAGES - NUM_QUEUES), "free page count after init");
        report("reset_state");

        // First packet of queue q lands on page q, word 0
        for (int k = 0; k < NUM_QUEUES; k++) begin
            run_op(1'b1, k, $urandom_range(MTU_BYTES, 1), 1'b0, 0);
        end
        report("enqueue_placement");

        for (int k = 0; k < 4; k++) begin
            run_op(1'b1, 3, MTU_BYTES, 1'b0, 0);
        end
        report("page_allocation");

        guard = 0;
        while (word_bytes[3].size() > 0 && guard < 100) begin
            run_op(1'b0, 0, 0, 1'b1, 3);
            guard++;
        end
        // Queue 3 is empty now, so no response
        run_op(1'b0, 0, 0, 1'b1, 3);
        report("dequeue_and_free");

        run_op(1'b1, 5, 2 * BYTES_PER_WORD, 1'b1, 5);
        run_op(1'b1, 5, BYTES_PER_WORD, 1'b1, 5);
        for (int k = 0; k < 80; k++) begin
            r = $urandom_range(3, 0);
            q = $urandom_range(NUM_QUEUES - 1, 0);
            run_op((r != 1) && (free_q.size() > 1), q, $urandom_range(MTU_BYTES, 1), r != 0,
                   (r == 3) ? $urandom_range(NUM_QUEUES - 1, 0) : q);
        end
        report("empty_flag_and_random");

        guard = 0;
        while (free_q.size() > 0 && guard < 100) begin
            run_op(1'b1, 0, MTU_BYTES, 1'b0, 0);
            guard++;
        end
        guard = 0;
        while (free_q.size() == 0 && word_bytes[0].size() > 0 && guard < 100) begin
            check(!enq_ready, "enq_ready high with no free page");
            run_op(1'b0, 0, 0, 1'b1, 0);
            guard++;
        end
        check(enq_ready, "enq_ready still low after a page was freed");
        run_op(1'b1, 0, MTU_BYTES, 1'b0, 0);
        report("back_pressure");

        for (int k = 0; k < NUM_QUEUES; k++) begin
            guard = 0;
            while (word_bytes[k].size() > 0 && guard < 600) begin
                run_op(1'b0, 0, 0, 1'b1, k);
                guard++;
            end
        end
        check(queue_empty == '1, "queues not all empty after draining");
        report("drain");

        $display("Done: %0d checks, %0d errors, timeout %0b", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
hw/qstate_pkg.sv
hw/qstate_ifc.sv
hw/page_allocator.sv
hw/tail_tracker.sv
hw/head_tracker.sv
hw/occupancy_tracker.sv
hw/qstate_top.sv
testbench/qstate_checker.sv
testbench/qstate_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the queue state keeper testbench with Verilator and runs it
set -u
cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module qstate_tb \
    --Mdir obj_dir -o qstate_sim > build.log 2>&1 \
    && ./obj_dir/qstate_sim > "$LOG" 2>&1 \
    || { cat build.log "$LOG" 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat "$LOG"
grep -q "Something failed" "$LOG" && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
